// ==== flist.f ====
+incdir+source
source/axil_pkg.sv
source/axi_pkg.sv
source/axi_axil_rd.sv
source/axi_axil_wr.sv
source/axil_sram.sv
source/axi_axil_bridge_top.sv
bench/axi_axil_bridge_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = axi_axil_bridge_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/axi_axil_bridge_tb.sv ====
`timescale 1ns/1ns
`include "axi_consts.svh"

module axi_axil_bridge_tb;

  localparam int MEM_WORDS  = 256;
  localparam int MAX_CYCLES = 4000;

  logic              clk;
  logic              rst_n;
  axi_pkg::ax_chan_t s_ar;
  logic              s_ar_valid;
  logic              s_ar_ready;
  axi_pkg::r_chan_t  s_r;
  logic              s_r_valid;
  logic              s_r_ready;
  axi_pkg::ax_chan_t s_aw;
  logic              s_aw_valid;
  logic              s_aw_ready;
  axi_pkg::w_chan_t  s_w;
  logic              s_w_valid;
  logic              s_w_ready;
  axi_pkg::b_chan_t  s_b;
  logic              s_b_valid;
  logic              s_b_ready;

  logic [`AXI_DATA_W-1:0] model [MEM_WORDS];
  logic [`AXI_DATA_W-1:0] wdata [16];
  axi_pkg::r_chan_t       rbeats [16];
  axi_pkg::b_chan_t       bresp;
  int                     cycles = 0;
  int                     errors = 0;
  int                     checks = 0;
  int                     tests = 0;

  axi_axil_bridge_top axi_axil_bridge_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_ar       (s_ar),
    .s_ar_valid (s_ar_valid),
    .s_ar_ready (s_ar_ready),
    .s_r        (s_r),
    .s_r_valid  (s_r_valid),
    .s_r_ready  (s_r_ready),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_w        (s_w),
    .s_w_valid  (s_w_valid),
    .s_w_ready  (s_w_ready),
    .s_b        (s_b),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Inputs change 2 ns after each rising edge.
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_r_chan(input string name, input axi_pkg::r_chan_t exp,
                              input axi_pkg::r_chan_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $write("** Error %s: expected id=%h data=%h resp=%s last=%b, ",
             name, exp.id, exp.data, exp.resp.name(), exp.last);
      $display("actual id=%h data=%h resp=%s last=%b",
               act.id, act.data, act.resp.name(), act.last);
    end
  endtask

  task automatic check_b_chan(input string name, input axi_pkg::b_chan_t exp,
                              input axi_pkg::b_chan_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected id=%h resp=%s, actual id=%h resp=%s",
               name, exp.id, exp.resp.name(), act.id, act.resp.name());
    end
  endtask

  function automatic logic [`AXI_ADDR_W-1:0] beat_addr(input logic [`AXI_ADDR_W-1:0] base,
                                                       input axi_pkg::burst_e burst, input int n);
    if (burst == axi_pkg::BURST_FIXED) begin
      return base;
    end
    return base + `AXI_ADDR_W'(2 * n);
  endfunction

  // Reference memory of 16-bit words.
  task automatic model_write(input logic [`AXI_ADDR_W-1:0] addr, input axi_pkg::w_chan_t beat);
    int idx;
    idx = int'(addr[`AXI_ADDR_W-1:1]);
    if (idx < MEM_WORDS) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (beat.strb[i]) begin
          model[idx][i*8 +: 8] = beat.data[i*8 +: 8];
        end
      end
    end
  endtask

  function automatic axi_pkg::r_chan_t expected_beat(input logic [`AXI_ID_W-1:0] id,
                                                     input logic [`AXI_ADDR_W-1:0] addr,
                                                     input logic last);
    int               idx;
    axi_pkg::r_chan_t e;
    idx    = int'(addr[`AXI_ADDR_W-1:1]);
    e.id   = id;
    e.last = last;
    if (idx < MEM_WORDS) begin
      e.data = model[idx];
      e.resp = axil_pkg::RESP_OKAY;
    end else begin
      e.data = '0;
      e.resp = axil_pkg::RESP_SLVERR;
    end
    return e;
  endfunction

  task automatic axi_write_burst(input logic [`AXI_ID_W-1:0] id,
                                 input logic [`AXI_ADDR_W-1:0] addr, input int len,
                                 input axi_pkg::burst_e burst,
                                 input logic [`AXI_STRB_W-1:0] strb, input bit gaps);
    logic fire;
    s_aw       = '{id: id, addr: addr, len: `AXI_LEN_W'(len), size: 3'd1, burst: burst};
    s_aw_valid = 1'b1;
    do begin
      #1 fire = s_aw_ready;
      tick();
    end while (!fire);
    s_aw_valid = 1'b0;
    for (int n = 0; n <= len; n++) begin
      if (gaps) begin
        repeat ($urandom_range(2)) tick();
      end
      s_w       = '{data: wdata[n], strb: strb, last: (n == len)};
      s_w_valid = 1'b1;
      do begin
        #1 fire = s_w_ready;
        tick();
      end while (!fire);
      s_w_valid = 1'b0;
      model_write(beat_addr(addr, burst, n), s_w);
    end
    s_b_ready = 1'b1;
    do begin
      #1 fire = s_b_valid;
      bresp = s_b;
      tick();
    end while (!fire);
    s_b_ready = 1'b0;
  endtask

  task automatic axi_read_burst(input string name, input logic [`AXI_ID_W-1:0] id,
                                input logic [`AXI_ADDR_W-1:0] addr, input int len,
                                input axi_pkg::burst_e burst, input bit random_ready);
    logic fire;
    int   got;
    s_ar       = '{id: id, addr: addr, len: `AXI_LEN_W'(len), size: 3'd1, burst: burst};
    s_ar_valid = 1'b1;
    do begin
      #1 fire = s_ar_ready;
      tick();
    end while (!fire);
    s_ar_valid = 1'b0;
    got = 0;
    while (got <= len) begin
      s_r_ready = random_ready ? 1'($urandom_range(1)) : 1'b1;
      #1;
      if (s_r_valid && s_r_ready) begin
        rbeats[got] = s_r;
        got++;
      end
      tick();
    end
    // Nothing may follow the last beat.
    s_r_ready = 1'b1;
    repeat (2) begin
      #1 check_flag({name, " extra beat"}, 1'b0, s_r_valid);
      tick();
    end
    s_r_ready = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("Test %s finished with %0d mismatches", name, errors - errors_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    #1;
    check_flag("reset s_ar_ready", 1'b1, s_ar_ready);
    check_flag("reset s_aw_ready", 1'b1, s_aw_ready);
    check_flag("reset s_r_valid", 1'b0, s_r_valid);
    check_flag("reset s_b_valid", 1'b0, s_b_valid);
    tick();
    finish_test("reset", e0);
  endtask

  task automatic test_strobe();
    int e0;
    e0 = errors;
    wdata[0] = 16'ha5c3;
    axi_write_burst(4'h1, 20'h00008, 0, axi_pkg::BURST_INCR, 2'b11, 1'b0);
    wdata[0] = 16'h7712;
    axi_write_burst(4'h1, 20'h00008, 0, axi_pkg::BURST_INCR, 2'b01, 1'b0);
    check_b_chan("strobe b", axi_pkg::b_chan_t'{id: 4'h1, resp: axil_pkg::RESP_OKAY}, bresp);
    axi_read_burst("strobe", 4'h2, 20'h00008, 0, axi_pkg::BURST_INCR, 1'b0);
    check_r_chan("strobe r", axi_pkg::r_chan_t'{id: 4'h2, data: 16'ha512,
                 resp: axil_pkg::RESP_OKAY, last: 1'b1}, rbeats[0]);
    check_r_chan("strobe model", expected_beat(4'h2, 20'h00008, 1'b1), rbeats[0]);
    finish_test("strobe", e0);
  endtask

  task automatic test_incr();
    int e0;
    e0 = errors;
    for (int n = 0; n < 4; n++) begin
      wdata[n] = 16'($urandom);
    end
    axi_write_burst(4'h3, 20'h00010, 3, axi_pkg::BURST_INCR, 2'b11, 1'b0);
    check_b_chan("incr b", axi_pkg::b_chan_t'{id: 4'h3, resp: axil_pkg::RESP_OKAY}, bresp);
    axi_read_burst("incr", 4'h5, 20'h00010, 3, axi_pkg::BURST_INCR, 1'b0);
    for (int n = 0; n < 4; n++) begin
      check_r_chan("incr r", axi_pkg::r_chan_t'{id: 4'h5, data: wdata[n],
                   resp: axil_pkg::RESP_OKAY, last: (n == 3)}, rbeats[n]);
    end
    finish_test("incr", e0);
  endtask

  task automatic test_fixed();
    int e0;
    e0 = errors;
    for (int n = 0; n < 3; n++) begin
      wdata[n] = 16'($urandom);
    end
    axi_write_burst(4'h6, 20'h00020, 2, axi_pkg::BURST_FIXED, 2'b11, 1'b0);
    check_b_chan("fixed b", axi_pkg::b_chan_t'{id: 4'h6, resp: axil_pkg::RESP_OKAY}, bresp);
    axi_read_burst("fixed", 4'h7, 20'h00020, 2, axi_pkg::BURST_FIXED, 1'b0);
    for (int n = 0; n < 3; n++) begin
      check_r_chan("fixed r", axi_pkg::r_chan_t'{id: 4'h7, data: wdata[2],
                   resp: axil_pkg::RESP_OKAY, last: (n == 2)}, rbeats[n]);
    end
    finish_test("fixed", e0);
  endtask

  // Words 254 and 255 exist but 256 and 257 do not.
  task automatic test_mem_end();
    int e0;
    e0 = errors;
    for (int n = 0; n < 4; n++) begin
      wdata[n] = 16'($urandom);
    end
    axi_write_burst(4'h9, 20'h001fc, 3, axi_pkg::BURST_INCR, 2'b11, 1'b0);
    check_b_chan("mem_end b", axi_pkg::b_chan_t'{id: 4'h9, resp: axil_pkg::RESP_SLVERR}, bresp);
    axi_read_burst("mem_end", 4'ha, 20'h001fc, 3, axi_pkg::BURST_INCR, 1'b0);
    for (int n = 0; n < 4; n++) begin
      check_r_chan("mem_end r", expected_beat(4'ha, beat_addr(20'h001fc, axi_pkg::BURST_INCR, n),
                   (n == 3)), rbeats[n]);
    end
    finish_test("mem_end", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    for (int n = 0; n < 8; n++) begin
      wdata[n] = 16'($urandom);
    end
    axi_write_burst(4'hb, 20'h00040, 7, axi_pkg::BURST_INCR, 2'b11, 1'b1);
    check_b_chan("stall b", axi_pkg::b_chan_t'{id: 4'hb, resp: axil_pkg::RESP_OKAY}, bresp);
    axi_read_burst("stall", 4'hc, 20'h00040, 7, axi_pkg::BURST_INCR, 1'b1);
    for (int n = 0; n < 8; n++) begin
      check_r_chan("stall r", expected_beat(4'hc, beat_addr(20'h00040, axi_pkg::BURST_INCR, n),
                   (n == 7)), rbeats[n]);
    end
    finish_test("backpressure", e0);
  endtask

  initial begin
    void'($urandom(32'hc5c1edde));
    rst_n      = 1'b0;
    s_ar       = '0;
    s_ar_valid = 1'b0;
    s_r_ready  = 1'b0;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    s_b_ready  = 1'b0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;
    test_reset();
    test_strobe();
    test_incr();
    test_fixed();
    test_mem_end();
    test_backpressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== source/axi_axil_bridge_top.sv ====
`timescale 1ns/1ns

module axi_axil_bridge_top (
  input  logic              clk,
  input  logic              rst_n,
  input  axi_pkg::ax_chan_t s_ar,
  input  logic              s_ar_valid,
  output logic              s_ar_ready,
  output axi_pkg::r_chan_t  s_r,
  output logic              s_r_valid,
  input  logic              s_r_ready,
  input  axi_pkg::ax_chan_t s_aw,
  input  logic              s_aw_valid,
  output logic              s_aw_ready,
  input  axi_pkg::w_chan_t  s_w,
  input  logic              s_w_valid,
  output logic              s_w_ready,
  output axi_pkg::b_chan_t  s_b,
  output logic              s_b_valid,
  input  logic              s_b_ready
);

  axil_pkg::ax_chan_t rd_ar;
  logic               rd_ar_valid;
  logic               rd_ar_ready;
  axil_pkg::r_chan_t  rd_r;
  logic               rd_r_valid;
  logic               rd_r_ready;
  axil_pkg::ax_chan_t wr_aw;
  logic               wr_aw_valid;
  logic               wr_aw_ready;
  axil_pkg::w_chan_t  wr_w;
  logic               wr_w_valid;
  logic               wr_w_ready;
  axil_pkg::resp_e    wr_b;
  logic               wr_b_valid;
  logic               wr_b_ready;

  axi_axil_rd axi_axil_rd_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_ar       (s_ar),
    .s_ar_valid (s_ar_valid),
    .s_ar_ready (s_ar_ready),
    .s_r        (s_r),
    .s_r_valid  (s_r_valid),
    .s_r_ready  (s_r_ready),
    .m_ar       (rd_ar),
    .m_ar_valid (rd_ar_valid),
    .m_ar_ready (rd_ar_ready),
    .m_r        (rd_r),
    .m_r_valid  (rd_r_valid),
    .m_r_ready  (rd_r_ready)
  );

  axi_axil_wr axi_axil_wr_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .s_w        (s_w),
    .s_w_valid  (s_w_valid),
    .s_w_ready  (s_w_ready),
    .s_b        (s_b),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready),
    .m_aw       (wr_aw),
    .m_aw_valid (wr_aw_valid),
    .m_aw_ready (wr_aw_ready),
    .m_w        (wr_w),
    .m_w_valid  (wr_w_valid),
    .m_w_ready  (wr_w_ready),
    .m_b        (wr_b),
    .m_b_valid  (wr_b_valid),
    .m_b_ready  (wr_b_ready)
  );

  axil_sram #(
    .MEM_WORDS (256)
  ) axil_sram_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar       (rd_ar),
    .ar_valid (rd_ar_valid),
    .ar_ready (rd_ar_ready),
    .r        (rd_r),
    .r_valid  (rd_r_valid),
    .r_ready  (rd_r_ready),
    .aw       (wr_aw),
    .aw_valid (wr_aw_valid),
    .aw_ready (wr_aw_ready),
    .w        (wr_w),
    .w_valid  (wr_w_valid),
    .w_ready  (wr_w_ready),
    .b        (wr_b),
    .b_valid  (wr_b_valid),
    .b_ready  (wr_b_ready)
  );

endmodule

// ==== source/axil_sram.sv ====
`timescale 1ns/1ns
`include "axi_consts.svh"

module axil_sram #(
  parameter int MEM_WORDS = 256
) (
  input  logic               clk,
  input  logic               rst_n,
  input  axil_pkg::ax_chan_t ar,
  input  logic               ar_valid,
  output logic               ar_ready,
  output axil_pkg::r_chan_t  r,
  output logic               r_valid,
  input  logic               r_ready,
  input  axil_pkg::ax_chan_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axil_pkg::w_chan_t  w,
  input  logic               w_valid,
  output logic               w_ready,
  output axil_pkg::resp_e    b,
  output logic               b_valid,
  input  logic               b_ready
);

  localparam int OFS_W = $clog2(`AXI_STRB_W);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [`AXI_DATA_W-1:0]       mem [MEM_WORDS];
  logic [`AXI_ADDR_W-OFS_W-1:0] rd_word;
  logic [`AXI_ADDR_W-OFS_W-1:0] wr_word;
  logic                         rd_ok;
  logic                         wr_ok;
  logic                         ar_fire;
  logic                         wr_go;

  assign rd_word = ar.addr[`AXI_ADDR_W-1:OFS_W];
  assign wr_word = aw.addr[`AXI_ADDR_W-1:OFS_W];
  assign rd_ok   = 32'(rd_word) < MEM_WORDS;
  assign wr_ok   = 32'(wr_word) < MEM_WORDS;

  // One read per cycle while the response register drains.
  assign ar_ready = !r_valid || r_ready;
  assign ar_fire  = ar_valid && ar_ready;

  // Address and data are taken together.
  assign wr_go    = aw_valid && w_valid && (!b_valid || b_ready);
  assign aw_ready = wr_go;
  assign w_ready  = wr_go;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
      if (wr_go) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      r.data <= rd_ok ? mem[rd_word[IDX_W-1:0]] : '0;
      r.resp <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    end
    if (wr_go) begin
      b <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
    end
    // Byte lanes without a strobe keep their old value.
    if (wr_go && wr_ok) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (w.strb[i]) begin
          mem[wr_word[IDX_W-1:0]][i*8 +: 8] <= w.data[i*8 +: 8];
        end
      end
    end
  end

  a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

// ==== source/axi_axil_wr.sv ====
`timescale 1ns/1ns
`include "axi_consts.svh"

module axi_axil_wr (
  input  logic               clk,
  input  logic               rst_n,
  input  axi_pkg::ax_chan_t  s_aw,
  input  logic               s_aw_valid,
  output logic               s_aw_ready,
  input  axi_pkg::w_chan_t   s_w,
  input  logic               s_w_valid,
  output logic               s_w_ready,
  output axi_pkg::b_chan_t   s_b,
  output logic               s_b_valid,
  input  logic               s_b_ready,
  output axil_pkg::ax_chan_t m_aw,
  output logic               m_aw_valid,
  input  logic               m_aw_ready,
  output axil_pkg::w_chan_t  m_w,
  output logic               m_w_valid,
  input  logic               m_w_ready,
  input  axil_pkg::resp_e    m_b,
  input  logic               m_b_valid,
  output logic               m_b_ready
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e               state_q;
  logic [`AXI_ID_W-1:0]    id_q;
  axi_pkg::burst_e         burst_q;
  logic [2:0]              size_q;
  logic [`AXI_LEN_W-1:0]   len_q;
  logic [`AXI_ADDR_W-1:0]  addr_q;
  logic [`AXI_ADDR_W-1:0]  addr_step;
  logic [`AXI_LEN_W:0]     sent_q;
  logic [`AXI_LEN_W-1:0]   acked_q;
  logic                    err_q;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;

  assign s_aw_ready = (state_q == WR_IDLE);
  assign aw_fire    = s_aw_valid && s_aw_ready;

  // A beat is taken only when both Lite registers are empty.
  assign s_w_ready = (state_q == WR_DATA) && !m_aw_valid && !m_w_valid &&
                     (sent_q <= {1'b0, len_q});
  assign w_fire    = s_w_valid && s_w_ready;

  assign addr_step = (burst_q == axi_pkg::BURST_FIXED) ? '0 : (`AXI_ADDR_W'(1) << size_q);

  assign m_b_ready = (state_q == WR_DATA);
  assign b_fire    = m_b_valid && m_b_ready;

  // One response for the whole burst and SLVERR if any beat failed.
  assign s_b_valid = (state_q == WR_RESP);
  assign s_b.id    = id_q;
  assign s_b.resp  = err_q ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= WR_IDLE;
      sent_q     <= '0;
      acked_q    <= '0;
      err_q      <= 1'b0;
      m_aw_valid <= 1'b0;
      m_w_valid  <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            state_q <= WR_DATA;
            sent_q  <= '0;
            acked_q <= '0;
            err_q   <= 1'b0;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            sent_q <= sent_q + 1'b1;
          end
          if (b_fire) begin
            acked_q <= acked_q + 1'b1;
            if (m_b == axil_pkg::RESP_SLVERR) begin
              err_q <= 1'b1;
            end
            if (acked_q == len_q) begin
              state_q <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (s_b_ready) begin
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase

      if (w_fire) begin
        m_aw_valid <= 1'b1;
      end else if (m_aw_ready) begin
        m_aw_valid <= 1'b0;
      end
      if (w_fire) begin
        m_w_valid <= 1'b1;
      end else if (m_w_ready) begin
        m_w_valid <= 1'b0;
      end
    end
  end

  // Burst attributes and the registered Lite pair.
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q    <= s_aw.id;
      burst_q <= s_aw.burst;
      size_q  <= s_aw.size;
      len_q   <= s_aw.len;
      addr_q  <= s_aw.addr;
    end else if (w_fire) begin
      addr_q <= addr_q + addr_step;
    end
    if (w_fire) begin
      m_aw.addr <= addr_q;
      m_w.data  <= s_w.data;
      m_w.strb  <= s_w.strb;
    end
  end

  // The master must mark the final beat of the burst, and only that one.
  a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> (s_w.last == (sent_q == {1'b0, len_q})));

endmodule

// ==== source/axi_axil_rd.sv ====
`timescale 1ns/1ns
`include "axi_consts.svh"

module axi_axil_rd (
  input  logic               clk,
  input  logic               rst_n,
  input  axi_pkg::ax_chan_t  s_ar,
  input  logic               s_ar_valid,
  output logic               s_ar_ready,
  output axi_pkg::r_chan_t   s_r,
  output logic               s_r_valid,
  input  logic               s_r_ready,
  output axil_pkg::ax_chan_t m_ar,
  output logic               m_ar_valid,
  input  logic               m_ar_ready,
  input  axil_pkg::r_chan_t  m_r,
  input  logic               m_r_valid,
  output logic               m_r_ready
);

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  rd_state_e                state_q;
  logic [`AXI_ID_W-1:0]     id_q;
  axi_pkg::burst_e          burst_q;
  logic [2:0]               size_q;
  logic [`AXI_LEN_W-1:0]    len_q;
  logic [`AXI_ADDR_W-1:0]   addr_q;
  logic [`AXI_ADDR_W-1:0]   addr_step;
  logic [`AXI_LEN_W:0]      issued_q;
  logic [`AXI_LEN_W-1:0]    returned_q;
  logic [`AXI_OUTST_W-1:0]  inflight_q;
  logic                     ar_fire;
  logic                     ar_issue;
  logic                     r_fire;
  logic                     last_beat;

  assign s_ar_ready = (state_q == RD_IDLE);
  assign ar_fire    = s_ar_valid && s_ar_ready;

  // Issue while beats remain and the in-flight window has room.
  assign m_ar_valid = (state_q == RD_BURST) &&
                      (issued_q <= {1'b0, len_q}) &&
                      (inflight_q < `AXI_OUTST_W'(`AXI_MAX_OUTST));
  assign m_ar       = '{addr: addr_q};
  assign ar_issue   = m_ar_valid && m_ar_ready;

  // FIXED bursts hit the same address every beat.
  assign addr_step = (burst_q == axi_pkg::BURST_FIXED) ? '0 : (`AXI_ADDR_W'(1) << size_q);

  // Lite data goes straight through with the burst ID attached.
  assign last_beat = (returned_q == len_q);
  assign s_r       = '{id: id_q, data: m_r.data, resp: m_r.resp, last: last_beat};
  assign s_r_valid = m_r_valid;
  assign m_r_ready = s_r_ready;
  assign r_fire    = m_r_valid && m_r_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= RD_IDLE;
      issued_q   <= '0;
      returned_q <= '0;
      inflight_q <= '0;
    end else begin
      if (ar_fire) begin
        state_q    <= RD_BURST;
        issued_q   <= '0;
        returned_q <= '0;
      end else begin
        if (ar_issue) begin
          issued_q <= issued_q + 1'b1;
        end
        if (r_fire) begin
          returned_q <= returned_q + 1'b1;
          if (last_beat) begin
            state_q <= RD_IDLE;
          end
        end
      end
      case ({ar_issue, r_fire})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Burst attributes and the stepping address.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q    <= s_ar.id;
      burst_q <= s_ar.burst;
      size_q  <= s_ar.size;
      len_q   <= s_ar.len;
      addr_q  <= s_ar.addr;
    end else if (ar_issue) begin
      addr_q <= addr_q + addr_step;
    end
  end

  a_outst_limit: assert property (@(posedge clk) disable iff (!rst_n)
    inflight_q <= `AXI_OUTST_W'(`AXI_MAX_OUTST));

  // The memory answers only reads this converter has issued.
  a_no_stray_r: assert property (@(posedge clk) disable iff (!rst_n)
    m_r_valid |-> inflight_q != '0);

endmodule

// ==== source/axi_pkg.sv ====
`include "axi_consts.svh"

package axi_pkg;

  // WRAP is stepped like INCR by the converters.
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Shared by AR and AW.
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
    logic [2:0]             size;
    burst_e                 burst;
  } ax_chan_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } w_chan_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    axil_pkg::resp_e        resp;
    logic                   last;
  } r_chan_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    axil_pkg::resp_e      resp;
  } b_chan_t;

endpackage

// ==== source/axil_pkg.sv ====
`include "axi_consts.svh"

package axil_pkg;

  // Only the two codes the memory produces.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Read or write address.
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
  } ax_chan_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    resp_e                  resp;
  } r_chan_t;

endpackage

// ==== source/axi_consts.svh ====
`ifndef AXI_CONSTS_SVH
`define AXI_CONSTS_SVH

// Byte address width on both the full and the Lite side.
`define AXI_ADDR_W 20

// Data bus width and its byte strobes.
`define AXI_DATA_W 16
`define AXI_STRB_W (`AXI_DATA_W / 8)

// Transaction ID and burst length widths.
`define AXI_ID_W 4
`define AXI_LEN_W 8

// Lite reads kept in flight by the read converter.
`define AXI_MAX_OUTST 4
`define AXI_OUTST_W 3

`endif
